// File: verilog/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define EXEC_DATA_WIDTH      32
`define EXEC_REG_ADDR_WIDTH  5
`define EXEC_ALU_OP_WIDTH    4

// Primary opcodes, bits 31:26
`define EXEC_OPC_RTYPE   6'h00
`define EXEC_OPC_BEQ     6'h04
`define EXEC_OPC_BNE     6'h05
`define EXEC_OPC_ADDIU   6'h09
`define EXEC_OPC_SLTI    6'h0a
`define EXEC_OPC_SLTIU   6'h0b
`define EXEC_OPC_ANDI    6'h0c
`define EXEC_OPC_ORI     6'h0d
`define EXEC_OPC_XORI    6'h0e

// R-type function codes, bits 5:0
`define EXEC_FN_SLL      6'h00
`define EXEC_FN_SRL      6'h02
`define EXEC_FN_SRA      6'h03
`define EXEC_FN_MFHI     6'h10
`define EXEC_FN_MFLO     6'h12
`define EXEC_FN_MULTU    6'h19
`define EXEC_FN_DIVU     6'h1b
`define EXEC_FN_ADDU     6'h21
`define EXEC_FN_SUBU     6'h23
`define EXEC_FN_AND      6'h24
`define EXEC_FN_OR       6'h25
`define EXEC_FN_XOR      6'h26
`define EXEC_FN_NOR      6'h27
`define EXEC_FN_SLT      6'h2a
`define EXEC_FN_SLTU     6'h2b

`endif

// File: verilog/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

	////////////////////////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////////////////////////

	// Register format
	typedef struct packed {
		logic [5:0]                      opcode;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] rs;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] rt;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] rd;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] shamt;
		logic [5:0]                      funct;
	} instr_r_t;

	// Immediate format
	typedef struct packed {
		logic [5:0]                      opcode;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] rs;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] rt;
		logic [15:0]                     imm;
	} instr_i_t;

	// Same 32 bits, read either way
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	// Codes 13 and 14 unused
	typedef enum logic [`EXEC_ALU_OP_WIDTH-1:0] {
		ALU_SLL  = 4'd0,
		ALU_SRA  = 4'd1,
		ALU_SRL  = 4'd2,
		ALU_MULU = 4'd3,
		ALU_DIVU = 4'd4,
		ALU_ADD  = 4'd5,
		ALU_SUB  = 4'd6,
		ALU_AND  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_XOR  = 4'd9,
		ALU_NOR  = 4'd10,
		ALU_SLT  = 4'd11,
		ALU_SLTU = 4'd12,
		ALU_NONE = 4'd15
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// Stage control and result
	////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e                         alu_op;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] shamt;
		logic                            use_imm;
		logic                            imm_signed;
		logic [15:0]                     imm;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] dest;
		logic                            hilo_write;
		logic                            sel_hi;
		logic                            sel_lo;
		logic                            is_beq;
		logic                            is_bne;
	} ex_ctrl_t;

	typedef struct packed {
		logic                            valid;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] dest;
		logic [`EXEC_DATA_WIDTH-1:0]     data;
		logic                            branch_taken;
	} ex_result_t;

endpackage

// File: verilog/alu_control.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module alu_control
(
	input  exec_pkg::instr_u   instr,
	output exec_pkg::ex_ctrl_t ctrl
);

	always_comb
	begin
		// Start from a no-op with no destination
		ctrl = '0;
		ctrl.alu_op = exec_pkg::ALU_NONE;
		ctrl.shamt = instr.r.shamt;
		ctrl.imm = instr.i.imm;

		// Opcode sits in the same bits in both views
		case (instr.i.opcode)
			`EXEC_OPC_RTYPE:
			begin
				// Writers go to rd
				ctrl.dest = instr.r.rd;
				case (instr.r.funct)
					`EXEC_FN_SLL:  ctrl.alu_op = exec_pkg::ALU_SLL;
					`EXEC_FN_SRL:  ctrl.alu_op = exec_pkg::ALU_SRL;
					`EXEC_FN_SRA:  ctrl.alu_op = exec_pkg::ALU_SRA;
					`EXEC_FN_ADDU: ctrl.alu_op = exec_pkg::ALU_ADD;
					`EXEC_FN_SUBU: ctrl.alu_op = exec_pkg::ALU_SUB;
					`EXEC_FN_AND:  ctrl.alu_op = exec_pkg::ALU_AND;
					`EXEC_FN_OR:   ctrl.alu_op = exec_pkg::ALU_OR;
					`EXEC_FN_XOR:  ctrl.alu_op = exec_pkg::ALU_XOR;
					`EXEC_FN_NOR:  ctrl.alu_op = exec_pkg::ALU_NOR;
					`EXEC_FN_SLT:  ctrl.alu_op = exec_pkg::ALU_SLT;
					`EXEC_FN_SLTU: ctrl.alu_op = exec_pkg::ALU_SLTU;
					// HI/LO reads bypass the ALU
					`EXEC_FN_MFHI: ctrl.sel_hi = 1'b1;
					`EXEC_FN_MFLO: ctrl.sel_lo = 1'b1;
					`EXEC_FN_MULTU:
					begin
						ctrl.alu_op = exec_pkg::ALU_MULU;
						ctrl.hilo_write = 1'b1;
						ctrl.dest = '0;
					end
					`EXEC_FN_DIVU:
					begin
						ctrl.alu_op = exec_pkg::ALU_DIVU;
						ctrl.hilo_write = 1'b1;
						ctrl.dest = '0;
					end
					// Unknown funct, no write
					default: ctrl.dest = '0;
				endcase
			end

			////////////////////////////////////////////////////////////
			// Immediate forms, result goes to rt
			////////////////////////////////////////////////////////////

			`EXEC_OPC_ADDIU, `EXEC_OPC_SLTI, `EXEC_OPC_SLTIU:
			begin
				// Sign-extended immediate group
				ctrl.use_imm = 1'b1;
				ctrl.imm_signed = 1'b1;
				ctrl.dest = instr.i.rt;
				if (instr.i.opcode == `EXEC_OPC_ADDIU)
					ctrl.alu_op = exec_pkg::ALU_ADD;
				else if (instr.i.opcode == `EXEC_OPC_SLTI)
					ctrl.alu_op = exec_pkg::ALU_SLT;
				else
					ctrl.alu_op = exec_pkg::ALU_SLTU;
			end
			`EXEC_OPC_ANDI, `EXEC_OPC_ORI, `EXEC_OPC_XORI:
			begin
				// Logic ops zero-extend
				ctrl.use_imm = 1'b1;
				ctrl.dest = instr.i.rt;
				if (instr.i.opcode == `EXEC_OPC_ANDI)
					ctrl.alu_op = exec_pkg::ALU_AND;
				else if (instr.i.opcode == `EXEC_OPC_ORI)
					ctrl.alu_op = exec_pkg::ALU_OR;
				else
					ctrl.alu_op = exec_pkg::ALU_XOR;
			end

			// Branches compare rs with rt, only the equal flag matters
			`EXEC_OPC_BEQ:
			begin
				ctrl.alu_op = exec_pkg::ALU_SUB;
				ctrl.is_beq = 1'b1;
			end
			`EXEC_OPC_BNE:
			begin
				ctrl.alu_op = exec_pkg::ALU_SUB;
				ctrl.is_bne = 1'b1;
			end
			default: ctrl.dest = '0;
		endcase
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module alu
(
	input  logic [`EXEC_DATA_WIDTH-1:0]     a_data,
	input  logic [`EXEC_DATA_WIDTH-1:0]     b_data,
	input  exec_pkg::alu_op_e               op,
	input  logic [`EXEC_REG_ADDR_WIDTH-1:0] shamt,
	output logic [`EXEC_DATA_WIDTH-1:0]     result_lo,
	output logic [`EXEC_DATA_WIDTH-1:0]     result_hi,
	output logic                            equal
);

	logic [2*`EXEC_DATA_WIDTH-1:0] product;
	logic [`EXEC_DATA_WIDTH-1:0]   quotient;
	logic [`EXEC_DATA_WIDTH-1:0]   remainder;

	////////////////////////////////////////////////////////////
	// Wide arithmetic
	////////////////////////////////////////////////////////////

	// Full 64-bit unsigned product
	assign product = {{`EXEC_DATA_WIDTH{1'b0}}, a_data} * {{`EXEC_DATA_WIDTH{1'b0}}, b_data};

	always_comb
	begin
		// Zero divisor gives all ones and keeps the dividend
		if (b_data == '0)
		begin
			quotient = '1;
			remainder = a_data;
		end
		else
		begin
			quotient = a_data / b_data;
			remainder = a_data % b_data;
		end
	end

	// Branch compare on the raw operands
	assign equal = (a_data == b_data);

	////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// High half only used by multiply and divide
		result_hi = '0;
		case (op)
			// Shifts act on b, which is rt for R-type
			exec_pkg::ALU_SLL:  result_lo = b_data << shamt;
			exec_pkg::ALU_SRL:  result_lo = b_data >> shamt;
			exec_pkg::ALU_SRA:  result_lo = $signed(b_data) >>> shamt;
			exec_pkg::ALU_MULU:
			begin
				result_lo = product[`EXEC_DATA_WIDTH-1:0];
				result_hi = product[2*`EXEC_DATA_WIDTH-1:`EXEC_DATA_WIDTH];
			end
			exec_pkg::ALU_DIVU:
			begin
				// Quotient low, remainder high
				result_lo = quotient;
				result_hi = remainder;
			end
			// Wraparound, no overflow trap
			exec_pkg::ALU_ADD:  result_lo = a_data + b_data;
			exec_pkg::ALU_SUB:  result_lo = a_data - b_data;
			exec_pkg::ALU_AND:  result_lo = a_data & b_data;
			exec_pkg::ALU_OR:   result_lo = a_data | b_data;
			exec_pkg::ALU_XOR:  result_lo = a_data ^ b_data;
			exec_pkg::ALU_NOR:  result_lo = ~(a_data | b_data);
			// Set-less-than, zero-extended flag
			exec_pkg::ALU_SLT:
			begin
				result_lo = '0;
				result_lo[0] = ($signed(a_data) < $signed(b_data));
			end
			exec_pkg::ALU_SLTU:
			begin
				result_lo = '0;
				result_lo[0] = (a_data < b_data);
			end
			// ALU_NONE and spare codes
			default: result_lo = '0;
		endcase
	end

endmodule

// File: verilog/hilo_regs.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module hilo_regs
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        write,
	input  logic [`EXEC_DATA_WIDTH-1:0] lo_in,
	input  logic [`EXEC_DATA_WIDTH-1:0] hi_in,
	output logic [`EXEC_DATA_WIDTH-1:0] lo,
	output logic [`EXEC_DATA_WIDTH-1:0] hi
);

	// Pair always loaded together
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lo <= '0;
			hi <= '0;
		end
		else if (write)
		begin
			lo <= lo_in;
			hi <= hi_in;
		end
	end

	// Visible to mfhi/mflo on the next edge

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Multiply/divide results must be clean when captured
	hilo_write_known: assert property (
		@(posedge clk) disable iff (reset)
		write |-> !$isunknown({lo_in, hi_in})
	);

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        in_valid,
	input  exec_pkg::instr_u            instr,
	input  logic [`EXEC_DATA_WIDTH-1:0] rs_data,
	input  logic [`EXEC_DATA_WIDTH-1:0] rt_data,
	output exec_pkg::ex_result_t        result
);

	exec_pkg::ex_ctrl_t          ctrl;
	logic [`EXEC_DATA_WIDTH-1:0] imm_ext;
	logic [`EXEC_DATA_WIDTH-1:0] b_data;
	logic [`EXEC_DATA_WIDTH-1:0] alu_lo;
	logic [`EXEC_DATA_WIDTH-1:0] alu_hi;
	logic [`EXEC_DATA_WIDTH-1:0] lo;
	logic [`EXEC_DATA_WIDTH-1:0] hi;
	logic [`EXEC_DATA_WIDTH-1:0] wb_data;
	logic                        alu_equal;
	logic                        branch_taken;

	alu_control alu_control_i (.instr(instr), .ctrl(ctrl));

	// Operand b is rt or the extended immediate
	assign imm_ext = ctrl.imm_signed ?
		{{(`EXEC_DATA_WIDTH-16){ctrl.imm[15]}}, ctrl.imm} :
		{{(`EXEC_DATA_WIDTH-16){1'b0}}, ctrl.imm};
	assign b_data = ctrl.use_imm ? imm_ext : rt_data;

	alu alu_i (
		.a_data(rs_data), .b_data(b_data), .op(ctrl.alu_op), .shamt(ctrl.shamt),
		.result_lo(alu_lo), .result_hi(alu_hi), .equal(alu_equal)
	);

	// Only a valid multu/divu updates the pair
	hilo_regs hilo_regs_i (
		.clk(clk), .reset(reset), .write(in_valid & ctrl.hilo_write),
		.lo_in(alu_lo), .hi_in(alu_hi), .lo(lo), .hi(hi)
	);

	// Writeback select and branch decision
	assign wb_data = ctrl.sel_hi ? hi : (ctrl.sel_lo ? lo : alu_lo);
	assign branch_taken = (ctrl.is_beq & alu_equal) | (ctrl.is_bne & ~alu_equal);

	////////////////////////////////////////////////////////////
	// Output register with one cycle latency
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
		begin
			// Valid pulses once per issued instruction
			result.valid <= in_valid;
			if (in_valid)
			begin
				result.dest <= ctrl.dest;
				result.data <= wb_data;
				result.branch_taken <= branch_taken;
			end
		end
	end

	result_valid_known: assert property (
		@(posedge clk) disable iff (reset) !$isunknown(result.valid)
	);

	// multu, divu, branches and unknown encodings land with dest 0
	no_write_dest_zero: assert property (
		@(posedge clk) disable iff (reset)
		in_valid && (ctrl.hilo_write || ctrl.is_beq || ctrl.is_bne ||
			(ctrl.alu_op == exec_pkg::ALU_NONE && !ctrl.sel_hi && !ctrl.sel_lo))
		|=> result.dest == '0
	);

endmodule

// File: tests/exec_stage_tb.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_stage_tb;

	// Layout of a table row or a random row
	typedef struct packed {
		logic [31:0]                     instr;
		logic [`EXEC_DATA_WIDTH-1:0]     rs_data;
		logic [`EXEC_DATA_WIDTH-1:0]     rt_data;
		logic [`EXEC_DATA_WIDTH-1:0]     exp_data;
		logic [`EXEC_REG_ADDR_WIDTH-1:0] exp_dest;
		logic                            exp_branch;
	} vec_t;

	localparam int NUM_RANDOM = 200;

	logic                        clk;
	logic                        reset;
	logic                        in_valid;
	exec_pkg::instr_u            instr;
	logic [`EXEC_DATA_WIDTH-1:0] rs_data;
	logic [`EXEC_DATA_WIDTH-1:0] rt_data;
	exec_pkg::ex_result_t        result;

	vec_t       vectors[$];
	vec_t       pending;
	logic       have_pending;
	logic [5:0] r_functs[$];
	logic [5:0] i_opcodes[$];
	int         mismatches;
	int         other_errors;
	int         cycles;
	int         n;

	exec_stage exec_stage_i (
		.clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr),
		.rs_data(rs_data), .rt_data(rt_data), .result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit from reset, table, random run and some slack
	initial
	begin
		cycles = 0;
		while (cycles < 16 + vectors.size() + NUM_RANDOM + 20)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: timeout, run still going after %0d cycles", cycles);
		$display("Something failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Encoding and expected values
	////////////////////////////////////////////////////////////

	// Register data comes in on the ports so rs and rt stay zero
	function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] sh);
		return {`EXEC_OPC_RTYPE, 10'd0, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] opc, input logic [4:0] rt,
		input logic [15:0] imm);
		return {opc, 5'd0, rt, imm};
	endfunction

	// Covers ALU instructions only since HI/LO cases live in the table
	function automatic void predict(input logic [31:0] w, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] data, output logic [4:0] dest,
		output logic br);
		logic [31:0] sext;
		logic [31:0] zext;
		sext = {{16{w[15]}}, w[15:0]};
		zext = {16'h0000, w[15:0]};
		data = '0;
		br = 1'b0;
		dest = (w[31:26] == `EXEC_OPC_RTYPE) ? w[15:11] : w[20:16];
		if (w[31:26] == `EXEC_OPC_RTYPE)
		begin
			case (w[5:0])
				`EXEC_FN_SLL:  data = b << w[10:6];
				`EXEC_FN_SRL:  data = b >> w[10:6];
				`EXEC_FN_SRA:  data = $signed(b) >>> w[10:6];
				`EXEC_FN_ADDU: data = a + b;
				`EXEC_FN_SUBU: data = a - b;
				`EXEC_FN_AND:  data = a & b;
				`EXEC_FN_OR:   data = a | b;
				`EXEC_FN_XOR:  data = a ^ b;
				`EXEC_FN_NOR:  data = ~(a | b);
				`EXEC_FN_SLT:  data = {31'd0, $signed(a) < $signed(b)};
				`EXEC_FN_SLTU: data = {31'd0, a < b};
				default:       dest = '0;
			endcase
		end
		else
		begin
			case (w[31:26])
				`EXEC_OPC_ADDIU: data = a + sext;
				`EXEC_OPC_SLTI:  data = {31'd0, $signed(a) < $signed(sext)};
				`EXEC_OPC_SLTIU: data = {31'd0, a < sext};
				`EXEC_OPC_ANDI:  data = a & zext;
				`EXEC_OPC_ORI:   data = a | zext;
				`EXEC_OPC_XORI:  data = a ^ zext;
				// Branches never write
				`EXEC_OPC_BEQ:
				begin
					dest = '0;
					br = (a == b);
				end
				`EXEC_OPC_BNE:
				begin
					dest = '0;
					br = (a != b);
				end
				default: dest = '0;
			endcase
		end
	endfunction

	function automatic vec_t random_vec();
		vec_t v;
		int   sel;
		sel = $urandom_range(0, r_functs.size() + i_opcodes.size() - 1);
		v.rs_data = $urandom;
		v.rt_data = $urandom;
		// Equal operands now and then for beq/bne
		if ($urandom_range(0, 3) == 0)
			v.rt_data = v.rs_data;
		if (sel < r_functs.size())
			v.instr = r_word(r_functs[sel], $urandom_range(1, 31), $urandom);
		else
			v.instr = i_word(i_opcodes[sel - r_functs.size()], $urandom_range(1, 31),
				$urandom);
		predict(v.instr, v.rs_data, v.rt_data, v.exp_data, v.exp_dest, v.exp_branch);
		return v;
	endfunction

	task automatic add_vec(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] data, input logic [4:0] dest, input logic br);
		vectors.push_back({w, a, b, data, dest, br});
	endtask

	task automatic build_vectors();
		// Shifts act on rt
		add_vec(r_word(`EXEC_FN_SLL, 1, 4), 0, 32'h0000_0001, 32'h0000_0010, 1, 0);
		add_vec(r_word(`EXEC_FN_SRL, 2, 31), 0, 32'h8000_0000, 32'h0000_0001, 2, 0);
		add_vec(r_word(`EXEC_FN_SRA, 3, 4), 0, 32'hf000_0000, 32'hff00_0000, 3, 0);
		// Wraparound and logic
		add_vec(r_word(`EXEC_FN_ADDU, 4, 0), 32'hffff_ffff, 2, 32'h0000_0001, 4, 0);
		add_vec(r_word(`EXEC_FN_SUBU, 5, 0), 1, 2, 32'hffff_ffff, 5, 0);
		add_vec(r_word(`EXEC_FN_AND, 6, 0), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000, 6, 0);
		add_vec(r_word(`EXEC_FN_OR, 7, 0), 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0, 7, 0);
		add_vec(r_word(`EXEC_FN_XOR, 8, 0), 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0, 8, 0);
		add_vec(r_word(`EXEC_FN_NOR, 9, 0), 32'hf0f0_f0f0, 32'h0f0f_0000, 32'h0000_0f0f, 9, 0);
		// Sign against zero extension of immediates
		add_vec(i_word(`EXEC_OPC_ADDIU, 10, 16'hffff), 5, 0, 32'h0000_0004, 10, 0);
		add_vec(i_word(`EXEC_OPC_ANDI, 11, 16'h8001), 32'hffff_ffff, 0, 32'h0000_8001, 11, 0);
		add_vec(i_word(`EXEC_OPC_ORI, 12, 16'h8000), 32'h1234_0000, 0, 32'h1234_8000, 12, 0);
		add_vec(i_word(`EXEC_OPC_XORI, 13, 16'hffff), 32'hffff_0000, 0, 32'hffff_ffff, 13, 0);
		// Signed against unsigned compares
		add_vec(r_word(`EXEC_FN_SLT, 14, 0), 32'h8000_0000, 1, 1, 14, 0);
		add_vec(r_word(`EXEC_FN_SLTU, 15, 0), 32'h8000_0000, 1, 0, 15, 0);
		add_vec(i_word(`EXEC_OPC_SLTI, 16, 16'hffff), 1, 0, 0, 16, 0);
		add_vec(i_word(`EXEC_OPC_SLTIU, 17, 16'hffff), 1, 0, 1, 17, 0);
		add_vec(i_word(`EXEC_OPC_SLTI, 18, 16'h0001), 32'h8000_0000, 0, 1, 18, 0);
		add_vec(i_word(`EXEC_OPC_SLTIU, 19, 16'h0001), 32'h8000_0000, 0, 0, 19, 0);
		// multu with rd set still writes nothing
		add_vec(r_word(`EXEC_FN_MULTU, 9, 0), 32'hffff_ffff, 32'hffff_ffff, 0, 0, 0);
		add_vec(r_word(`EXEC_FN_MFHI, 20, 0), 0, 0, 32'hffff_fffe, 20, 0);
		add_vec(r_word(`EXEC_FN_MFLO, 21, 0), 0, 0, 32'h0000_0001, 21, 0);
		// divu leaves the remainder in HI
		add_vec(r_word(`EXEC_FN_DIVU, 9, 0), 100, 7, 0, 0, 0);
		add_vec(r_word(`EXEC_FN_MFHI, 22, 0), 0, 0, 2, 22, 0);
		add_vec(r_word(`EXEC_FN_MFLO, 23, 0), 0, 0, 14, 23, 0);
		// Divide by zero
		add_vec(r_word(`EXEC_FN_DIVU, 9, 0), 32'h1234_5678, 0, 0, 0, 0);
		add_vec(r_word(`EXEC_FN_MFHI, 24, 0), 0, 0, 32'h1234_5678, 24, 0);
		add_vec(r_word(`EXEC_FN_MFLO, 25, 0), 0, 0, 32'hffff_ffff, 25, 0);
		// Branches
		add_vec(i_word(`EXEC_OPC_BEQ, 3, 16'h0010), 5, 5, 0, 0, 1);
		add_vec(i_word(`EXEC_OPC_BEQ, 3, 16'h0010), 5, 6, 0, 0, 0);
		add_vec(i_word(`EXEC_OPC_BNE, 3, 16'h0010), 5, 6, 0, 0, 1);
		add_vec(i_word(`EXEC_OPC_BNE, 3, 16'h0010), 7, 7, 0, 0, 0);
		// Unsupported opcode and funct
		add_vec(i_word(6'h3f, 26, 16'h1234), 1, 2, 0, 0, 0);
		add_vec(r_word(6'h3f, 27, 0), 1, 2, 0, 0, 0);
	endtask

	////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////

	// Data only means something when a register is written
	task automatic check_result(input vec_t e);
		if (result.valid !== 1'b1)
		begin
			$display("ERROR at %0t: no valid result one cycle after issue", $time);
			other_errors++;
		end
		else
		begin
			if (result.dest !== e.exp_dest)
			begin
				$display("MISMATCH at %0t: dest got %0d expected %0d", $time,
					result.dest, e.exp_dest);
				mismatches++;
			end
			if (e.exp_dest != 0 && result.data !== e.exp_data)
			begin
				$display("MISMATCH at %0t: data got %h expected %h", $time,
					result.data, e.exp_data);
				mismatches++;
			end
			if (result.branch_taken !== e.exp_branch)
			begin
				$display("MISMATCH at %0t: branch_taken got %b expected %b", $time,
					result.branch_taken, e.exp_branch);
				mismatches++;
			end
		end
	endtask

	// On the falling edge check the previous issue and drive the next
	task automatic step(input vec_t v);
		@(negedge clk);
		if (have_pending)
			check_result(pending);
		in_valid = 1'b1;
		instr = v.instr;
		rs_data = v.rs_data;
		rt_data = v.rt_data;
		pending = v;
		have_pending = 1'b1;
	endtask

	initial
	begin
		void'($urandom(32'h04c12a32));
		reset = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		rs_data = '0;
		rt_data = '0;
		mismatches = 0;
		other_errors = 0;
		have_pending = 1'b0;
		r_functs = '{`EXEC_FN_SLL, `EXEC_FN_SRL, `EXEC_FN_SRA, `EXEC_FN_ADDU, `EXEC_FN_SUBU,
			`EXEC_FN_AND, `EXEC_FN_OR, `EXEC_FN_XOR, `EXEC_FN_NOR, `EXEC_FN_SLT, `EXEC_FN_SLTU};
		i_opcodes = '{`EXEC_OPC_ADDIU, `EXEC_OPC_ANDI, `EXEC_OPC_ORI, `EXEC_OPC_XORI,
			`EXEC_OPC_SLTI, `EXEC_OPC_SLTIU, `EXEC_OPC_BEQ, `EXEC_OPC_BNE};
		build_vectors();

		repeat (16) @(negedge clk);
		reset = 1'b0;

		// Output stays cleared while idle after reset
		repeat (2)
		begin
			@(negedge clk);
			if (result !== '0)
			begin
				$display("ERROR at %0t: result not cleared with nothing issued", $time);
				other_errors++;
			end
		end

		// Back-to-back table followed by random ALU traffic
		foreach (vectors[i])
			step(vectors[i]);
		for (n = 0; n < NUM_RANDOM; n++)
			step(random_vec());

		// Check the last result and let valid drop
		@(negedge clk);
		check_result(pending);
		in_valid = 1'b0;
		@(negedge clk);
		if (result.valid !== 1'b0)
		begin
			$display("ERROR at %0t: valid stayed high after the last instruction", $time);
			other_errors++;
		end

		$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/alu_control.sv
verilog/alu.sv
verilog/hilo_regs.sv
verilog/exec_stage.sv
tests/exec_stage_tb.sv
